// ==== Makefile ====
# verilator flow for the fetch sequencer testbench
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# build, run, then search the log for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
logic/fetch_pkg.sv
logic/fetch_fsm.sv
logic/access_timer.sv
logic/start_manager.sv
logic/context_ram.sv
logic/fetch_top.sv
tests/fetch_asserts.sv
tests/fetch_tb.sv

// ==== logic/access_timer.sv ====
`timescale 1ns/10ps

module access_timer
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  mem_req_t  req,
  output mem_done_t done
);

  lat_cnt_t cnt;
  // kind of the access in flight
  logic     is_wr;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt   <= '0;
      is_wr <= 1'b0;
      done  <= '0;
    end else begin
      done <= '0;
      if (req.rd || req.wr) begin
        // strobe cycle counts as the first latency cycle
        cnt   <= lat_cnt_t'(ACCESS_LATENCY - 1);
        is_wr <= req.wr;
      end else if (cnt != '0) begin
        cnt <= cnt - lat_cnt_t'(1);
        // last count, fire the matching pulse
        if (cnt == lat_cnt_t'(1)) begin
          done.rd_dn <= ~is_wr;
          done.wr_dn <= is_wr;
        end
      end
    end
  end

endmodule

// ==== logic/context_ram.sv ====
`timescale 1ns/10ps

module context_ram
  import fetch_pkg::*;
(
  input  logic     clk,
  input  logic     host_sel,
  input  logic     host_we,
  input  addr_t    host_addr,
  input  data_t    host_wdata,
  input  mem_req_t req,
  output data_t    rdata
);

  // registers and program share one array
  data_t mem [RAM_DEPTH];

  addr_t sel_addr;
  data_t sel_wdata;
  logic  sel_we;
  logic  sel_re;

  // host owns the port only while the sequencer is idle
  always_comb begin
    if (host_sel) begin
      sel_addr  = host_addr;
      sel_wdata = host_wdata;
      sel_we    = host_we;
      // host reads every cycle
      sel_re    = 1'b1;
    end else begin
      sel_addr  = req.addr;
      sel_wdata = req.wdata;
      sel_we    = req.wr;
      // sequencer read data held between strobes
      sel_re    = req.rd;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_we) begin
      mem[sel_addr] <= sel_wdata;
    end
    // read before write on the same address
    if (sel_re) begin
      rdata <= mem[sel_addr];
    end
  end

endmodule

// ==== logic/fetch_fsm.sv ====
`timescale 1ns/10ps

module fetch_fsm
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  mem_done_t    done,
  output fetch_state_t state,
  output logic         access_go,
  output logic         busy,
  output logic         cmd_valid
);

  fetch_state_t state_next;
  logic         go_next;
  logic         entering;

  // phase sequencing
  always_comb begin
    state_next = state;
    case (state)
      // start pulses outside idle fall through here unseen
      st_idle: begin
        if (start) begin
          state_next = st_begin;
        end
      end
      // single cycle, pointer preload happens here
      st_begin: begin
        state_next = st_read_ip;
      end
      // wait for ip read to come back
      st_read_ip: begin
        if (done.rd_dn) begin
          state_next = st_read_cmd;
        end
      end
      // wait for command word
      st_read_cmd: begin
        if (done.rd_dn) begin
          state_next = st_preexecute;
        end
      end
      // single cycle, pointer increments
      st_preexecute: begin
        state_next = st_write_ip;
      end
      // wait for ip write back
      st_write_ip: begin
        if (done.wr_dn) begin
          state_next = st_done;
        end
      end
      // command presented for one cycle
      st_done: begin
        state_next = st_idle;
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // access go only on the edge into an access phase
  assign entering = (state_next != state);
  assign go_next  = entering &&
                    ((state_next == st_read_ip) ||
                     (state_next == st_read_cmd) ||
                     (state_next == st_write_ip));

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      access_go <= 1'b0;
    end else begin
      state     <= state_next;
      access_go <= go_next;
    end
  end

  // decoded from registered state
  assign busy      = (state != st_idle);
  assign cmd_valid = (state == st_done);

endmodule

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

  // context ram geometry
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int RAM_DEPTH = 1 << ADDR_W;

  // word address into the context ram
  typedef logic [ADDR_W-1:0] addr_t;
  // memory word, also the command word
  typedef logic [DATA_W-1:0] data_t;

  // ip register offset inside a context
  localparam addr_t REG_IP = addr_t'(4);

  // cycles from request strobe to done pulse
  localparam int ACCESS_LATENCY = 3;
  localparam int LAT_W = $clog2(ACCESS_LATENCY);
  typedef logic [LAT_W-1:0] lat_cnt_t;

  // fetch sequencer phases
  typedef enum logic [2:0] {
    st_idle,
    st_begin,
    st_read_ip,
    st_read_cmd,
    st_preexecute,
    st_write_ip,
    st_done
  } fetch_state_t;

  // sequencer request, strobes last one cycle
  typedef struct packed {
    logic  rd;
    logic  wr;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  // completion pulses from the access timer
  typedef struct packed {
    logic rd_dn;
    logic wr_dn;
  } mem_done_t;

endpackage

// ==== logic/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  addr_t base_addr,
  input  logic  host_we,
  input  addr_t host_addr,
  input  data_t host_wdata,
  output logic  busy,
  output logic  cmd_valid,
  output data_t command,
  output data_t host_rdata
);

  fetch_state_t state;
  logic         access_go;
  mem_req_t     req;
  mem_done_t    done;
  // host port enable, inverse of busy
  logic         host_sel;

  assign host_sel = ~busy;

  // phase sequencer
  fetch_fsm u_fsm (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .done      (done),
    .state     (state),
    .access_go (access_go),
    .busy      (busy),
    .cmd_valid (cmd_valid)
  );

  // fixed latency per access
  access_timer u_timer (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .done (done)
  );

  // pointer, ip address and command
  start_manager u_start (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .access_go (access_go),
    .base_addr (base_addr),
    .rdata     (host_rdata),
    .done      (done),
    .req       (req),
    .command   (command)
  );

  // read register shared by host and sequencer
  context_ram u_ram (
    .clk        (clk),
    .host_sel   (host_sel),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .req        (req),
    .rdata      (host_rdata)
  );

endmodule

// ==== logic/start_manager.sv ====
`timescale 1ns/10ps

module start_manager
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  fetch_state_t state,
  input  logic         access_go,
  input  addr_t        base_addr,
  input  data_t        rdata,
  input  mem_done_t    done,
  output mem_req_t     req,
  output data_t        command
);

  // command pointer, the working copy of ip
  addr_t ptr;
  // where ip lives for this context
  addr_t ip_addr;

  assign ip_addr = base_addr + REG_IP;

  // request for the current phase
  always_comb begin
    req = '0;
    case (state)
      // ip value fetched from its context slot
      st_read_ip: begin
        req.rd   = access_go;
        req.addr = ip_addr;
      end
      // command word at the pointer
      st_read_cmd: begin
        req.rd   = access_go;
        req.addr = ptr;
      end
      // advanced pointer goes back to the ip slot
      st_write_ip: begin
        req.wr    = access_go;
        req.addr  = ip_addr;
        req.wdata = {{(DATA_W - ADDR_W){1'b0}}, ptr};
      end
      default: begin
        req = '0;
      end
    endcase
  end

  // pointer and command capture
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr     <= '0;
      command <= '0;
    end else begin
      case (state)
        // preload with the ip slot address
        st_begin: begin
          ptr <= ip_addr;
        end
        // ip value becomes the pointer
        st_read_ip: begin
          if (done.rd_dn) begin
            ptr <= rdata[ADDR_W-1:0];
          end
        end
        // command held until the next fetch
        st_read_cmd: begin
          if (done.rd_dn) begin
            command <= rdata;
          end
        end
        // step past the fetched word
        st_preexecute: begin
          ptr <= ptr + addr_t'(1);
        end
        default: begin
          ptr <= ptr;
        end
      endcase
    end
  end

endmodule

// ==== tests/fetch_asserts.sv ====
`timescale 1ns/10ps

module fetch_asserts
  import fetch_pkg::*;
(
  input logic         clk,
  input logic         rst,
  input logic         start,
  input logic         busy,
  input logic         cmd_valid,
  input fetch_state_t state,
  input mem_req_t     req
);

  // failed properties so far, watched from the testbench
  int fail_count = 0;

  // command valid is a pulse
  a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
    cmd_valid |=> !cmd_valid)
    else begin
      $error("cmd_valid high for more than one cycle");
      fail_count++;
    end

  // no new strobe while an access is in flight
  // rd and wr of different accesses never overlap
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    (req.rd || req.wr) |-> !(req.rd && req.wr) &&
      !$past(req.rd || req.wr, 1) &&
      !$past(req.rd || req.wr, 2) &&
      !$past(req.rd || req.wr, 3))
    else begin
      $error("rd and wr strobes overlap an access in flight");
      fail_count++;
    end

  // start seen mid fetch must not restart the sequence
  a_start_busy: assert property (@(posedge clk) disable iff (rst)
    (start && busy) |=> (state != st_begin))
    else begin
      $error("start while busy restarted the fetch");
      fail_count++;
    end

  // idle and quiet straight out of reset
  a_reset_idle: assert property (@(posedge clk)
    rst |=> (!busy && !cmd_valid && state == st_idle))
    else begin
      $error("sequencer not idle after reset");
      fail_count++;
    end

endmodule

bind fetch_top fetch_asserts i_asserts (
  .clk       (clk),
  .rst       (rst),
  .start     (start),
  .busy      (busy),
  .cmd_valid (cmd_valid),
  .state     (state),
  .req       (req)
);

// ==== tests/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb
  import fetch_pkg::*;
();

  // 1 + 8 + 6 + 1 fetches over the whole run
  localparam int N_FETCH   = 16;
  localparam int FETCH_CYC = 60;
  // host fill, three full readbacks, reset and idle gaps
  localparam int LOAD_CYC  = 4 * (RAM_DEPTH + 8) + 64;
  localparam int LIMIT_CYC = N_FETCH * FETCH_CYC + LOAD_CYC;

  logic  clk;
  logic  rst;
  logic  start;
  addr_t base_addr;
  logic  host_we;
  addr_t host_addr;
  data_t host_wdata;
  logic  busy;
  logic  cmd_valid;
  data_t command;
  data_t host_rdata;

  // reference copy of the context ram
  data_t model [RAM_DEPTH];
  // expected commands in fetch order
  data_t exp_q [$];
  int    seed = 18;
  int    cycles = 0;
  int    n_valid = 0;
  int    err_count = 0;

  fetch_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    err_count++;
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT_CYC) begin
      $display("timeout, DUT did not finish within %0d cycles", LIMIT_CYC);
      abort_run();
    end
  end

  // expected command for one fetch, model ip steps past it
  function automatic data_t next_fetch(addr_t base);
    addr_t ip_slot;
    addr_t ptr;
    addr_t ptr_next;
    data_t cmd;
    ip_slot = base + REG_IP;
    // pointer is the low address bits of ip
    ptr = model[ip_slot][ADDR_W-1:0];
    cmd = model[ptr];
    // wraps at the top of the ram, written back zero extended
    ptr_next = ptr + addr_t'(1);
    model[ip_slot] = data_t'(ptr_next);
    return cmd;
  endfunction

  // each presented command against the oldest expected one
  always @(negedge clk) begin
    data_t want;
    assert (i_dut.i_asserts.fail_count == 0) else begin
      $display("protocol assertion failed in the DUT before %0t", $time);
      abort_run();
    end
    if (!rst && cmd_valid) begin
      n_valid++;
      assert (exp_q.size() > 0) else begin
        $display("cmd_valid at %0t with no fetch outstanding", $time);
        abort_run();
      end
      want = exp_q.pop_front();
      assert (command == want) else begin
        $display("Fail at %0t: command = %h, expected %h", $time, command, want);
        abort_run();
      end
    end
  end

  task automatic host_write(addr_t a, data_t d);
    host_we    = 1'b1;
    host_addr  = a;
    host_wdata = d;
    model[a]   = d;
    @(negedge clk);
    host_we = 1'b0;
  endtask

  // read data registered, checked one cycle on
  task automatic host_check(addr_t a, data_t want);
    host_addr = a;
    @(negedge clk);
    assert (host_rdata == want) else begin
      $display("Fail at %0t: host_rdata[%h] = %h, expected %h", $time, a, host_rdata, want);
      abort_run();
    end
  endtask

  task automatic check_all();
    for (int i = 0; i < RAM_DEPTH; i++) begin
      host_check(addr_t'(i), model[i]);
    end
  endtask

  // one fetch, optionally a second start mid fetch
  task automatic run_fetch(addr_t base, logic poke_busy);
    exp_q.push_back(next_fetch(base));
    base_addr = base;
    start     = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (poke_busy) begin
      // lands in the ip read phase
      repeat (4) @(negedge clk);
      assert (busy) else begin
        $display("DUT not busy when the extra start was driven at %0t", $time);
        abort_run();
      end
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (!cmd_valid) begin
      @(negedge clk);
    end
    @(negedge clk);
    assert (!busy) else begin
      $display("Fail at %0t: busy = %b, expected 0 after cmd_valid", $time, busy);
      abort_run();
    end
  endtask

  initial begin
    addr_t base_a;
    addr_t base_b;
    addr_t ip0;
    addr_t ip1;
    start      = 1'b0;
    base_addr  = '0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    rst        = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    // random fill and readback
    for (int i = 0; i < RAM_DEPTH; i++) begin
      host_write(addr_t'(i), data_t'($random(seed)));
    end
    check_all();
    // single fetch, random context and ip
    base_a = addr_t'($random(seed));
    ip0    = addr_t'($random(seed));
    host_write(base_a + REG_IP, data_t'(ip0));
    run_fetch(base_a, 1'b0);
    // ip slot advanced by one word
    ip1 = ip0 + addr_t'(1);
    host_check(base_a + REG_IP, data_t'(ip1));
    // consecutive commands, same context
    repeat (8) run_fetch(base_a, 1'b0);
    // second context half the ram away
    base_b = base_a + addr_t'(8'h80);
    host_write(base_b + REG_IP, data_t'(addr_t'($random(seed))));
    for (int i = 0; i < 3; i++) begin
      run_fetch(base_a, 1'b0);
      run_fetch(base_b, 1'b0);
    end
    check_all();
    // ignored start, idle gap catches a stray second fetch
    run_fetch(base_b, 1'b1);
    repeat (40) @(negedge clk);
    check_all();
    assert (exp_q.size() == 0 && n_valid == N_FETCH) else begin
      $display("Fail at %0t: cmd_valid count = %0d, expected %0d", $time, n_valid, N_FETCH);
      abort_run();
    end
    if (err_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule
